// File: source/fsqrt_pkg.sv
// Floating-point square root
// Shared widths, codes and payload types

package fsqrt_pkg;

	// ======================================================================
	// Format widths
	// ======================================================================

	localparam int F32_EXP_W  = 8;
	localparam int F32_FRAC_W = 23;
	localparam int F16_EXP_W  = 5;
	localparam int F16_FRAC_W = 10;

	localparam int F32_BIAS = 127;
	localparam int F16_BIAS = 15;

	// Root bits developed: hidden bit, stored fraction and one round bit
	localparam int ROOT_W     = F32_FRAC_W + 2;
	localparam int ROOT_W_F16 = F16_FRAC_W + 2;

	// Two radicand bits are consumed for every root bit
	localparam int RAD_W = 2 * ROOT_W;
	localparam int REM_W = ROOT_W + 2;

	// ======================================================================
	// Rounding modes and flag positions
	// ======================================================================

	localparam logic [2:0] RM_RNE = 3'd0;
	localparam logic [2:0] RM_RTZ = 3'd1;
	localparam logic [2:0] RM_RDN = 3'd2;
	localparam logic [2:0] RM_RUP = 3'd3;
	localparam logic [2:0] RM_RMM = 3'd4;

	// Flag field is {NV, DZ, OF, UF, NX}
	localparam int FLAG_NV = 4;
	localparam int FLAG_NX = 0;

	// ======================================================================
	// Types
	// ======================================================================

	typedef enum logic {
		FMT_F16 = 1'b0,
		FMT_F32 = 1'b1
	} fmt_e;

	typedef struct packed {
		fmt_e        fmt;
		logic [31:0] op;
		logic [2:0]  rm;
	} sqrt_req_t;

	typedef struct packed {
		logic [31:0] res;
		logic [4:0]  flags;
	} sqrt_resp_t;

	// The same 32-bit word seen as binary32 or as binary16 in the low half
	typedef union packed {
		struct packed {
			logic                  sign;
			logic [F32_EXP_W-1:0]  exp;
			logic [F32_FRAC_W-1:0] frac;
		} f32;
		struct packed {
			logic [15:0]           unused;
			logic                  sign;
			logic [F16_EXP_W-1:0]  exp;
			logic [F16_FRAC_W-1:0] frac;
		} f16;
	} op_word_u;

	// Operand class and the result exponent before rounding
	typedef struct packed {
		logic       is_nan;
		logic       is_snan;
		logic       is_inf;
		logic       is_zero;
		logic       is_neg;
		logic       sign;
		logic [9:0] exp;
	} op_class_t;

endpackage

// File: source/fsqrt_ctrl_fsm.sv
// Square root control FSM

`timescale 1ns/1ps

module fsqrt_ctrl_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,
	input  logic req_valid_i,
	output logic req_ready_o,
	output logic resp_valid_o,
	input  logic resp_ready_i,
	input  logic is_special_i,
	input  logic last_i,
	output logic accept_o,
	output logic step_o
);

	typedef enum logic [1:0] {
		IDLE,
		ITER,
		DONE
	} state_e;

	state_e state_q;
	state_e state_d;

	// Handshakes and datapath steering all decode the current state
	assign req_ready_o  = (state_q == IDLE);
	assign resp_valid_o = (state_q == DONE);
	assign accept_o     = req_valid_i & req_ready_o;
	assign step_o       = (state_q == ITER);

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			// Special operands skip the recurrence and answer on the next cycle
			IDLE: if (accept_o) state_d = is_special_i ? DONE : ITER;
			// The counter flags the step that develops the round bit
			ITER: if (last_i) state_d = DONE;
			// Result and flags hold here until the consumer takes them
			DONE: if (resp_ready_i) state_d = IDLE;
			default: state_d = IDLE;
		endcase
		// Flush wins over any handshake in the same cycle
		if (flush_i)
			state_d = IDLE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// A normal operand must enter ITER with steps still left on the counter
	assert property (@(posedge clk) disable iff (!rst_n)
		(accept_o && !is_special_i) |=> !last_i)
		else $error("iteration count already at zero when ITER was entered");

endmodule

// File: source/fsqrt_iter_counter.sv
// Recurrence step counter

`timescale 1ns/1ps

module fsqrt_iter_counter
	import fsqrt_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic accept_i,
	input  logic step_i,
	input  fmt_e fmt_i,
	output logic last_o
);

	localparam int CNT_W = $clog2(ROOT_W);

	logic [CNT_W-1:0] cnt_q;

	// One step per root bit, so the last step happens at count zero
	always_ff @(posedge clk) begin
		if (accept_i) begin
			cnt_q <= (fmt_i == FMT_F16) ? CNT_W'(ROOT_W_F16 - 1) : CNT_W'(ROOT_W - 1);
		end else if (step_i && !last_o) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign last_o = (cnt_q == '0);

	// The FSM must leave ITER after the final step instead of running past zero
	assert property (@(posedge clk) disable iff (!rst_n) (step_i && last_o) |=> !step_i)
		else $error("recurrence step after the count reached zero");

endmodule

// File: source/fsqrt_unpack.sv
// Operand decode and radicand alignment

`timescale 1ns/1ps

module fsqrt_unpack
	import fsqrt_pkg::*;
(
	input  logic             clk,
	input  logic             accept_i,
	input  sqrt_req_t        req_i,
	output logic             is_special_o,
	output logic [RAD_W-1:0] radicand_o,
	output op_class_t        class_o,
	output fmt_e             fmt_o,
	output logic [2:0]       rm_o
);

	op_word_u              op_w;
	logic                  sign;
	logic [F32_EXP_W-1:0]  exp_b;
	logic [F32_FRAC_W-1:0] frac_a;
	logic [9:0]            bias;
	logic                  exp_max;
	logic                  exp_zero;
	logic                  frac_zero;
	logic [ROOT_W-1:0]     rad_top;
	op_class_t             class_d;
	op_class_t             class_q;
	fmt_e                  fmt_q;
	logic [2:0]            rm_q;

	assign op_w = req_i.op;

	// ======================================================================
	// Field extraction
	// ======================================================================

	// Binary16 fields are widened to binary32 size with the fraction MSB-aligned
	always_comb begin
		if (req_i.fmt == FMT_F16) begin
			sign    = op_w.f16.sign;
			exp_b   = {{(F32_EXP_W - F16_EXP_W){1'b0}}, op_w.f16.exp};
			frac_a  = {op_w.f16.frac, {(F32_FRAC_W - F16_FRAC_W){1'b0}}};
			exp_max = &op_w.f16.exp;
			bias    = 10'(F16_BIAS);
		end else begin
			sign    = op_w.f32.sign;
			exp_b   = op_w.f32.exp;
			frac_a  = op_w.f32.frac;
			exp_max = &op_w.f32.exp;
			bias    = 10'(F32_BIAS);
		end
	end

	assign exp_zero  = (exp_b == '0);
	assign frac_zero = (frac_a == '0);

	// Subnormals fall in with zeros and keep their sign
	always_comb begin
		class_d.is_nan  = exp_max & ~frac_zero;
		class_d.is_snan = exp_max & ~frac_zero & ~frac_a[F32_FRAC_W-1];
		class_d.is_inf  = exp_max & frac_zero;
		class_d.is_zero = exp_zero;
		class_d.is_neg  = sign & ~exp_zero & ~(exp_max & ~frac_zero);
		class_d.sign    = sign & exp_zero;
		// floor((exp - bias) / 2) + bias equals floor((exp + bias) / 2)
		class_d.exp     = 10'(({2'b00, exp_b} + bias) >> 1);
	end

	// Anything negative, NaN, infinite or zero takes the short path
	assign is_special_o = exp_max | exp_zero | sign;

	// The bias is odd, so an even biased exponent is an odd true exponent
	// and the mantissa doubles to keep the halved exponent exact
	assign rad_top    = exp_b[0] ? {2'b01, frac_a} : {1'b1, frac_a, 1'b0};
	assign radicand_o = {rad_top, {(RAD_W - ROOT_W){1'b0}}};

	always_ff @(posedge clk) begin
		if (accept_i) begin
			class_q <= class_d;
			fmt_q   <= req_i.fmt;
			rm_q    <= req_i.rm;
		end
	end

	assign class_o = class_q;
	assign fmt_o   = fmt_q;
	assign rm_o    = rm_q;

endmodule

// File: source/fsqrt_root_recurrence.sv
// Restoring square-root recurrence

`timescale 1ns/1ps

module fsqrt_root_recurrence
	import fsqrt_pkg::*;
(
	input  logic              clk,
	input  logic              accept_i,
	input  logic              step_i,
	input  logic [RAD_W-1:0]  radicand_i,
	output logic [ROOT_W-1:0] root_o,
	output logic              sticky_o
);

	logic [RAD_W-1:0]  rad_q;
	logic [REM_W-1:0]  rem_q;
	logic [ROOT_W-1:0] root_q;
	logic [REM_W-1:0]  rem_shift;
	logic [REM_W-1:0]  trial;
	logic              root_bit;

	// ======================================================================
	// One root bit per step
	// ======================================================================

	// The top two remainder bits are still zero whenever a step is taken
	assign rem_shift = {rem_q[REM_W-3:0], rad_q[RAD_W-1 -: 2]};

	// Trial value is 4*root + 1, which is (2*root + 1)^2 - (2*root)^2
	assign trial = {root_q, 2'b01};

	assign root_bit = (rem_shift >= trial);

	always_ff @(posedge clk) begin
		if (accept_i) begin
			rad_q  <= radicand_i;
			rem_q  <= '0;
			root_q <= '0;
		end else if (step_i) begin
			rad_q  <= rad_q << 2;
			rem_q  <= root_bit ? (rem_shift - trial) : rem_shift;
			root_q <= {root_q[ROOT_W-2:0], root_bit};
		end
	end

	// Binary16 leaves its root in the low ROOT_W_F16 bits after fewer steps
	assign root_o = root_q;

	// Any leftover remainder means the exact root lies below the developed bits
	assign sticky_o = |rem_q;

	// A remainder above 2*root would mean a root bit was wrongly rejected
	assert property (@(posedge clk) step_i |=> (rem_q <= {1'b0, root_q, 1'b0}))
		else $error("remainder exceeds twice the partial root");

endmodule

// File: source/fsqrt_round_pack.sv
// Rounding, special results and packing

`timescale 1ns/1ps

module fsqrt_round_pack
	import fsqrt_pkg::*;
(
	input  op_class_t         class_i,
	input  fmt_e              fmt_i,
	input  logic [2:0]        rm_i,
	input  logic [ROOT_W-1:0] root_i,
	input  logic              sticky_i,
	output sqrt_resp_t        resp_o
);

	logic                  f16;
	logic [F32_FRAC_W-1:0] kept;
	logic                  rnd;
	logic                  lsb;
	logic                  round_up;
	logic [F32_FRAC_W:0]   sum;
	logic                  carry;
	logic [F32_FRAC_W-1:0] frac_r;
	logic [9:0]            exp_r;
	logic                  nan_res;
	logic                  special;
	logic [9:0]            out_exp;
	logic [F32_FRAC_W-1:0] out_frac;
	op_word_u              res_w;

	assign f16 = (fmt_i == FMT_F16);

	// ======================================================================
	// Rounding of the developed root
	// ======================================================================

	// The hidden bit sits above the kept fraction and is dropped here
	assign kept = f16 ? {{(F32_FRAC_W - F16_FRAC_W){1'b0}}, root_i[ROOT_W_F16-2:1]}
	                  : root_i[ROOT_W-2:1];
	assign rnd  = root_i[0];
	assign lsb  = root_i[1];

	// Normal results are positive, so RTZ and RDN always truncate
	always_comb begin
		unique case (rm_i)
			RM_RNE:  round_up = rnd & (sticky_i | lsb);
			RM_RUP:  round_up = rnd | sticky_i;
			RM_RMM:  round_up = rnd;
			default: round_up = 1'b0;
		endcase
	end

	assign sum = {1'b0, kept} + (F32_FRAC_W + 1)'(round_up);

	// An all-ones fraction carries out into the exponent
	assign carry  = f16 ? sum[F16_FRAC_W] : sum[F32_FRAC_W];
	assign frac_r = carry ? '0 : sum[F32_FRAC_W-1:0];
	assign exp_r  = class_i.exp + 10'(carry);

	// ======================================================================
	// Special results and packing
	// ======================================================================

	// Negative nonzero operands share the canonical qNaN with NaN inputs
	assign nan_res = class_i.is_nan | class_i.is_neg;
	assign special = nan_res | class_i.is_inf | class_i.is_zero;

	always_comb begin
		if (nan_res) begin
			out_exp  = '1;
			out_frac = f16 ? F32_FRAC_W'(1 << (F16_FRAC_W - 1)) : F32_FRAC_W'(1 << (F32_FRAC_W - 1));
		end else if (class_i.is_inf) begin
			out_exp  = '1;
			out_frac = '0;
		end else if (class_i.is_zero) begin
			out_exp  = '0;
			out_frac = '0;
		end else begin
			out_exp  = exp_r;
			out_frac = frac_r;
		end
	end

	// Binary16 results sit in the low half with the upper half zero
	always_comb begin
		res_w = '0;
		if (f16) begin
			res_w.f16.sign = class_i.sign;
			res_w.f16.exp  = out_exp[F16_EXP_W-1:0];
			res_w.f16.frac = out_frac[F16_FRAC_W-1:0];
		end else begin
			res_w.f32.sign = class_i.sign;
			res_w.f32.exp  = out_exp[F32_EXP_W-1:0];
			res_w.f32.frac = out_frac;
		end
	end

	// Divide-by-zero, overflow and underflow can never occur and stay zero
	always_comb begin
		resp_o.res            = res_w;
		resp_o.flags          = '0;
		resp_o.flags[FLAG_NV] = class_i.is_snan | class_i.is_neg;
		resp_o.flags[FLAG_NX] = ~special & (rnd | sticky_i);
	end

endmodule

// File: source/fsqrt_top.sv
// Floating-point square root top level

`timescale 1ns/1ps

module fsqrt_top
	import fsqrt_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       flush_i,
	input  logic       req_valid_i,
	output logic       req_ready_o,
	input  sqrt_req_t  req_i,
	output logic       resp_valid_o,
	input  logic       resp_ready_i,
	output sqrt_resp_t resp_o
);

	// Steering between the controller and the datapath
	logic accept;
	logic step;
	logic last;
	logic is_special;

	// Datapath values
	logic [RAD_W-1:0]  radicand;
	logic [ROOT_W-1:0] root;
	logic              sticky;
	op_class_t         op_class;
	fmt_e              fmt_q;
	logic [2:0]        rm_q;

	fsqrt_ctrl_fsm fsqrt_ctrl_fsm (
		.clk(clk), .rst_n(rst_n), .flush_i(flush_i),
		.req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
		.resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i),
		.is_special_i(is_special), .last_i(last),
		.accept_o(accept), .step_o(step)
	);

	// The count is loaded from the incoming request format
	fsqrt_iter_counter fsqrt_iter_counter (
		.clk(clk), .rst_n(rst_n), .accept_i(accept), .step_i(step),
		.fmt_i(req_i.fmt), .last_o(last)
	);

	fsqrt_unpack fsqrt_unpack (
		.clk(clk), .accept_i(accept), .req_i(req_i), .is_special_o(is_special),
		.radicand_o(radicand), .class_o(op_class), .fmt_o(fmt_q), .rm_o(rm_q)
	);

	fsqrt_root_recurrence fsqrt_root_recurrence (
		.clk(clk), .accept_i(accept), .step_i(step), .radicand_i(radicand),
		.root_o(root), .sticky_o(sticky)
	);

	fsqrt_round_pack fsqrt_round_pack (
		.class_i(op_class), .fmt_i(fmt_q), .rm_i(rm_q), .root_i(root),
		.sticky_i(sticky), .resp_o(resp_o)
	);

endmodule

// File: tests/fsqrt_model.svh
// Square-root reference model and random source

`ifndef FSQRT_MODEL_SVH
`define FSQRT_MODEL_SVH

// One xorshift step on a 32-bit state
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Expected response for one request, built from the format rules
function automatic sqrt_resp_t ref_sqrt(input sqrt_req_t req);
	op_word_u    w;
	sqrt_resp_t  r;
	logic        f16;
	logic        s;
	logic        sticky;
	logic        up;
	int          fw;
	int          ex;
	int          emax;
	int          bias;
	int          e;
	int          res_e;
	logic [63:0] mant;
	logic [63:0] rad;
	logic [63:0] root;
	logic [63:0] cand;
	logic [63:0] frac;
	w    = req.op;
	f16  = (req.fmt == FMT_F16);
	fw   = f16 ? F16_FRAC_W : F32_FRAC_W;
	bias = f16 ? F16_BIAS : F32_BIAS;
	emax = f16 ? (1 << F16_EXP_W) - 1 : (1 << F32_EXP_W) - 1;
	s    = f16 ? w.f16.sign : w.f32.sign;
	ex   = f16 ? int'(w.f16.exp) : int'(w.f32.exp);
	mant = f16 ? 64'(w.f16.frac) : 64'(w.f32.frac);
	r    = '0;
	if (ex == emax && mant != 0) begin
		// Every NaN comes back as the canonical quiet NaN, invalid only when signaling
		r.res            = f16 ? 32'h0000_7e00 : 32'h7fc0_0000;
		r.flags[FLAG_NV] = ~mant[fw-1];
	end else if (s && ex != 0) begin
		// Negative nonzero operands, negative infinity included
		r.res            = f16 ? 32'h0000_7e00 : 32'h7fc0_0000;
		r.flags[FLAG_NV] = 1'b1;
	end else if (ex == emax) begin
		r.res = f16 ? 32'h0000_7c00 : 32'h7f80_0000;
	end else if (ex == 0) begin
		// Zeros and subnormals give a zero that keeps the operand sign
		r.res = f16 ? {16'h0, s, 15'h0} : {s, 31'h0};
	end else begin
		// An odd true exponent doubles the mantissa so the halved exponent stays exact
		e   = ex - bias;
		rad = (mant | (64'd1 << fw)) << (fw + 2 + (e & 1));
		// Greedy bit-by-bit integer square root, one bit beyond the kept fraction
		root = '0;
		for (int i = fw + 1; i >= 0; i--) begin
			cand = root | (64'd1 << i);
			if (cand * cand <= rad)
				root = cand;
		end
		sticky = (root * root != rad);
		frac   = (root >> 1) & ((64'd1 << fw) - 1);
		case (req.rm)
			RM_RNE:  up = root[0] & (sticky | frac[0]);
			RM_RUP:  up = root[0] | sticky;
			RM_RMM:  up = root[0];
			default: up = 1'b0;
		endcase
		res_e = (e >>> 1) + bias;
		frac  = frac + 64'(up);
		// Carry out of an all-ones fraction moves into the exponent
		if (frac[fw]) begin
			res_e = res_e + 1;
			frac  = '0;
		end
		r.res            = 32'(frac) | (32'(res_e) << fw);
		r.flags[FLAG_NX] = root[0] | sticky;
	end
	return r;
endfunction

`endif

// File: tests/fsqrt_tb.sv
// Floating-point square root testbench

`timescale 1ns/1ps

module fsqrt_tb
	import fsqrt_pkg::*;
;

	// ======================================================================
	// Run length and watchdog
	// ======================================================================

	localparam int N_F32_PER_RM = 40;
	localparam int N_F16_RAND   = 60;
	localparam int N_F16_CARRY  = 30;
	localparam int N_SPECIAL    = 10;
	localparam int N_HOLD       = 20;
	localparam int N_FLUSH      = 5;
	localparam int NUM_OPS      = 5 * N_F32_PER_RM + N_F16_RAND + N_F16_CARRY
		+ 2 * N_SPECIAL + N_HOLD + 2 * N_FLUSH;
	// Each operation fits well inside 40 cycles of 10 ns, doubled for margin
	localparam int WATCHDOG_NS  = 2 * NUM_OPS * 40 * 10;

	logic        clk;
	logic        rst_n;
	logic        flush;
	logic        req_valid;
	logic        req_ready;
	sqrt_req_t   req_data;
	logic        resp_valid;
	logic        resp_ready;
	sqrt_resp_t  resp_data;
	logic [31:0] rng_state;
	int          n_tests;
	int          n_checks;
	int          n_errors;

	`include "fsqrt_model.svh"

	fsqrt_top fsqrt_top_inst (
		.clk(clk), .rst_n(rst_n), .flush_i(flush),
		.req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req_data),
		.resp_valid_o(resp_valid), .resp_ready_i(resp_ready), .resp_o(resp_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the test sequence ended", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	// ======================================================================
	// Stimulus helpers
	// ======================================================================

	function automatic logic [31:0] rand_u32();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [2:0] rand_rm();
		return 3'(rand_u32() % 5);
	endfunction

	// Operands are assembled through the same union view the DUT decodes
	function automatic sqrt_req_t make_req(input fmt_e fmt, input logic sign, input int exp_v,
			input logic [22:0] frac, input logic [2:0] rm);
		op_word_u  w;
		sqrt_req_t r;
		w = '0;
		if (fmt == FMT_F16) begin
			w.f16.sign = sign;
			w.f16.exp  = exp_v[F16_EXP_W-1:0];
			w.f16.frac = frac[F16_FRAC_W-1:0];
		end else begin
			w.f32.sign = sign;
			w.f32.exp  = exp_v[F32_EXP_W-1:0];
			w.f32.frac = frac;
		end
		r.fmt = fmt;
		r.op  = w;
		r.rm  = rm;
		return r;
	endfunction

	function automatic sqrt_req_t rand_normal(input fmt_e fmt, input logic [2:0] rm);
		int emax;
		emax = (fmt == FMT_F16) ? 31 : 255;
		return make_req(fmt, 1'b0, 1 + int'(rand_u32() % 32'(emax - 1)), 23'(rand_u32()), rm);
	endfunction

	// Special operand number idx for the given format
	function automatic sqrt_req_t special_req(input fmt_e fmt, input int idx,
			input logic [2:0] rm);
		int          emax;
		int          fw;
		logic [22:0] r;
		emax = (fmt == FMT_F16) ? 31 : 255;
		fw   = (fmt == FMT_F16) ? F16_FRAC_W : F32_FRAC_W;
		r    = 23'(rand_u32());
		case (idx)
			0: return make_req(fmt, 1'b0, emax, 23'd1 << (fw - 1), rm);
			1: return make_req(fmt, 1'b0, emax, 23'd1, rm);
			2: return make_req(fmt, 1'b0, emax, 23'd0, rm);
			3: return make_req(fmt, 1'b1, emax, 23'd0, rm);
			4: return make_req(fmt, 1'b0, 0, 23'd0, rm);
			5: return make_req(fmt, 1'b1, 0, 23'd0, rm);
			6: return make_req(fmt, 1'b1, 1 + int'(r % 23'(emax - 1)), r, rm);
			7: return make_req(fmt, 1'b0, 0, r | 23'd1, rm);
			8: return make_req(fmt, 1'b1, 0, r | 23'd1, rm);
			default: return make_req(fmt, 1'b1, emax, (23'd1 << (fw - 1)) | 23'd1, rm);
		endcase
	endfunction

	// Cycles from the accept edge to resp_valid, by operand class
	function automatic int expected_latency(input sqrt_req_t r);
		op_word_u w;
		logic     s;
		int       e;
		int       emax;
		w    = r.op;
		s    = (r.fmt == FMT_F16) ? w.f16.sign : w.f32.sign;
		e    = (r.fmt == FMT_F16) ? int'(w.f16.exp) : int'(w.f32.exp);
		emax = (r.fmt == FMT_F16) ? 31 : 255;
		if (s || e == 0 || e == emax)
			return 1;
		return (r.fmt == FMT_F16) ? ROOT_W_F16 + 1 : ROOT_W + 1;
	endfunction

	// ======================================================================
	// Checks and the request/response driver
	// ======================================================================

	task automatic report_failure(input string msg);
		n_errors++;
		$display("%s", msg);
	endtask

	task automatic check_result(input string name, input sqrt_req_t req,
			input sqrt_resp_t exp_r, input sqrt_resp_t act_r);
		n_checks++;
		if (act_r.res !== exp_r.res) begin
			n_errors++;
			$display("Error %s: expected %h, actual %h (operand %h, rm %0d)",
				name, exp_r.res, act_r.res, req.op, req.rm);
		end
	endtask

	task automatic check_flags(input string name, input sqrt_req_t req,
			input sqrt_resp_t exp_r, input sqrt_resp_t act_r);
		n_checks++;
		if (act_r.flags !== exp_r.flags) begin
			n_errors++;
			$display("Error %s: expected %h, actual %h (operand %h, rm %0d)",
				name, exp_r.flags, act_r.flags, req.op, req.rm);
		end
	endtask

	// Called 1 ns after an edge, returns 1 ns after the consuming edge
	task automatic run_op(input sqrt_req_t req, input int hold, output sqrt_resp_t resp,
			output int lat);
		int wait_cyc;
		req_data  = req;
		req_valid = 1'b1;
		wait_cyc  = 0;
		while (!req_ready && wait_cyc < 100) begin
			@(posedge clk);
			#1;
			wait_cyc++;
		end
		if (!req_ready) begin
			report_failure("The request was never accepted within 100 cycles");
			req_valid = 1'b0;
			resp      = 'x;
			lat       = 0;
			return;
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		lat       = 1;
		while (!resp_valid && lat < 60) begin
			@(posedge clk);
			#1;
			lat++;
		end
		if (!resp_valid) begin
			report_failure("No response arrived within 60 cycles of the accept");
			resp = 'x;
			return;
		end
		resp = resp_data;
		// Back-pressure keeps the response and the handshake outputs frozen
		repeat (hold) begin
			@(posedge clk);
			#1;
			if (!resp_valid || req_ready)
				report_failure("Handshake outputs changed while the response was held back");
			check_result("resp_o.res (held)", req, resp, resp_data);
			check_flags("resp_o.flags (held)", req, resp, resp_data);
		end
		resp_ready = 1'b1;
		@(posedge clk);
		#1;
		resp_ready = 1'b0;
	endtask

	task automatic check_op(input sqrt_req_t req, input int hold);
		sqrt_resp_t exp_r;
		sqrt_resp_t act_r;
		int         lat;
		int         exp_lat;
		exp_r   = ref_sqrt(req);
		exp_lat = expected_latency(req);
		run_op(req, hold, act_r, lat);
		check_result("resp_o.res", req, exp_r, act_r);
		check_flags("resp_o.flags", req, exp_r, act_r);
		if (lat != exp_lat)
			report_failure($sformatf("Latency for operand %h was %0d cycles instead of %0d",
				req.op, lat, exp_lat));
	endtask

	// Flush somewhere inside ITER, then run one normal binary32 operation
	task automatic flush_during_iter();
		req_data  = rand_normal(FMT_F32, rand_rm());
		req_valid = 1'b1;
		while (!req_ready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		repeat (1 + int'(rand_u32() % 20)) begin
			@(posedge clk);
			#1;
		end
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		repeat (3) begin
			if (!req_ready || resp_valid)
				report_failure("The unit did not return to idle after a flush");
			@(posedge clk);
			#1;
		end
		check_op(rand_normal(FMT_F32, rand_rm()), 0);
	endtask

	task automatic end_test(input string name, input int ops, input int errs_before);
		n_tests++;
		$display("Test %s: %0d operations, %0d errors", name, ops, n_errors - errs_before);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		int start;
		rng_state  = 32'd50607;
		n_tests    = 0;
		n_checks   = 0;
		n_errors   = 0;
		rst_n      = 1'b0;
		flush      = 1'b0;
		req_valid  = 1'b0;
		req_data   = '0;
		resp_ready = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;

		// Normal binary32 operands in every rounding mode
		start = n_errors;
		for (int m = 0; m < 5; m++)
			for (int i = 0; i < N_F32_PER_RM; i++)
				check_op(rand_normal(FMT_F32, 3'(m)), 0);
		end_test("f32_random", 5 * N_F32_PER_RM, start);

		// Binary16, then all-ones fractions over every normal exponent
		// Rounding up makes every odd true exponent carry into the exponent
		start = n_errors;
		for (int i = 0; i < N_F16_RAND; i++)
			check_op(rand_normal(FMT_F16, rand_rm()), 0);
		for (int e = 1; e <= N_F16_CARRY; e++)
			check_op(make_req(FMT_F16, 1'b0, e, 23'h3ff, RM_RUP), 0);
		end_test("f16_random_carry", N_F16_RAND + N_F16_CARRY, start);

		start = n_errors;
		for (int f = 0; f < 2; f++)
			for (int i = 0; i < N_SPECIAL; i++)
				check_op(special_req(fmt_e'(f), i, rand_rm()), 0);
		end_test("special", 2 * N_SPECIAL, start);

		start = n_errors;
		for (int i = 0; i < N_HOLD; i++)
			check_op(rand_normal(fmt_e'(1'(rand_u32())), rand_rm()), 1 + int'(rand_u32() % 12));
		end_test("backpressure", N_HOLD, start);

		start = n_errors;
		for (int i = 0; i < N_FLUSH; i++)
			flush_during_iter();
		end_test("flush", 2 * N_FLUSH, start);

		$display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: fsqrt.f
+incdir+tests
source/fsqrt_pkg.sv
source/fsqrt_ctrl_fsm.sv
source/fsqrt_iter_counter.sv
source/fsqrt_unpack.sv
source/fsqrt_root_recurrence.sv
source/fsqrt_round_pack.sv
source/fsqrt_top.sv
tests/fsqrt_tb.sv

// File: Bender.yml
package:
  name: fsqrt

sources:
  - source/fsqrt_pkg.sv
  - source/fsqrt_ctrl_fsm.sv
  - source/fsqrt_iter_counter.sv
  - source/fsqrt_unpack.sv
  - source/fsqrt_root_recurrence.sv
  - source/fsqrt_round_pack.sv
  - source/fsqrt_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/fsqrt_tb.sv
